/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = tb_alu_subsystem
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* alu/alu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_core (
  input  wire alu_pkg::alu_cmd_t  cmd,
  output alu_pkg::alu_result_t    result
);
  import alu_pkg::*;

  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] sum;
  logic [31:0] diff;
  logic [31:0] shift_y;
  logic [31:0] value;
  logic        slt;
  logic        sltu;
  logic        add_ovf;
  logic        sub_ovf;
  logic        overflow;

  assign a = cmd.a;
  assign b = cmd.b;

  assign sum  = a + b;
  // Two's complement difference
  assign diff = a + ~b + 32'd1;
  assign slt  = $signed(a) < $signed(b);
  assign sltu = a < b;

  // Same-sign operands whose sum flips sign
  assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
  // Opposite signs and the result leaves A's sign
  assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

  alu_shifter u_shifter (
    .a     (a),
    .shamt (b[4:0]),
    .kind  (cmd.op),
    .y     (shift_y)
  );

  always_comb begin
    overflow = 1'b0;
    case (cmd.op)
      ALU_AND:                   value = a & b;
      ALU_OR:                    value = a | b;
      ALU_XOR:                   value = a ^ b;
      ALU_SLL, ALU_SRL, ALU_SRA: value = shift_y;
      ALU_ADD: begin
        value    = sum;
        overflow = add_ovf;
      end
      ALU_SUB: begin
        value    = diff;
        overflow = sub_ovf;
      end
      ALU_SLT:  value = {31'd0, slt};
      ALU_SLTU: value = {31'd0, sltu};
      default:  value = '0;
    endcase
  end

  assign result.value    = value;
  assign result.overflow = overflow;
  assign result.equal    = (a == b);
  assign result.zero     = (value == 32'd0);

endmodule

`default_nettype wire

/* alu/alu_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire alu_pkg::alu_cmd_t  cmd_front,
  input  wire                     cmd_empty,
  output logic                    cmd_pop,
  output logic                    res_push,
  output alu_pkg::alu_result_t    res_data,
  input  wire                     res_full
);
  import alu_pkg::*;

  alu_result_t core_result;
  alu_result_t data_q;
  logic        valid_q;

  alu_core u_core (
    .cmd    (cmd_front),
    .result (core_result)
  );

  // Output register drains when the result queue has room
  assign res_push = valid_q & ~res_full;
  // Take the next command if the output register is free or emptying
  assign cmd_pop  = ~cmd_empty & (~valid_q | ~res_full);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (cmd_pop) begin
      valid_q <= 1'b1;
    end else if (res_push) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      data_q <= core_result;
    end
  end

  assign res_data = data_q;

endmodule

`default_nettype wire

/* alu/alu_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_shifter (
  input  wire [31:0]            a,
  input  wire [4:0]             shamt,
  input  wire alu_pkg::alu_op_t kind,
  output logic [31:0]           y
);
  import alu_pkg::*;

  function automatic logic [31:0] bit_reverse(input logic [31:0] x);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = x[31 - i];
    end
    return r;
  endfunction

  logic        left;
  logic        fill;
  logic [31:0] stage [0:5];

  // Left shift reuses the right-shift stages on reversed bits
  assign left     = (kind == ALU_SLL);
  assign fill     = (kind == ALU_SRA) & a[31];
  assign stage[0] = left ? bit_reverse(a) : a;

  for (genvar i = 0; i < 5; i++) begin : g_stage
    localparam int SH = 1 << i;
    assign stage[i+1] = shamt[i] ? {{SH{fill}}, stage[i][31:SH]} : stage[i];
  end

  always_comb begin
    case (kind)
      ALU_SLL:          y = bit_reverse(stage[5]);
      ALU_SRL, ALU_SRA: y = stage[5];
      default:          y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // Operation codes from the processor's decode
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0001,
    ALU_OR   = 4'b0010,
    ALU_XOR  = 4'b0011,
    ALU_SLL  = 4'b0101,
    ALU_SRL  = 4'b0110,
    ALU_SRA  = 4'b0111,
    ALU_ADD  = 4'b1000,
    ALU_SUB  = 4'b1100,
    ALU_SLT  = 4'b1101,
    ALU_SLTU = 4'b1111
  } alu_op_t;

  typedef struct packed {
    alu_op_t     op;
    logic [31:0] a;
    logic [31:0] b;
  } alu_cmd_t;

  typedef struct packed {
    logic [31:0] value;
    logic        overflow;
    logic        equal;
    logic        zero;
  } alu_result_t;

  // Master side of the Wishbone classic bus
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Register byte addresses
  localparam logic [7:0] REG_OPA    = 8'h00;
  localparam logic [7:0] REG_OPB    = 8'h04;
  localparam logic [7:0] REG_CMD    = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0C;
  localparam logic [7:0] REG_RESULT = 8'h10;
  localparam logic [7:0] REG_FLAGS  = 8'h14;

  // STATUS fields
  localparam int unsigned STAT_CMD_COUNT_LSB = 0;
  localparam int unsigned STAT_RES_COUNT_LSB = 8;
  localparam int unsigned STAT_CMD_FULL      = 16;
  localparam int unsigned STAT_RES_EMPTY     = 17;

  // FLAGS bits
  localparam int unsigned FLAG_ZERO     = 0;
  localparam int unsigned FLAG_EQUAL    = 1;
  localparam int unsigned FLAG_OVERFLOW = 2;

endpackage

`default_nettype wire

/* hw/alu_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             push,
  input  wire [WIDTH-1:0] push_data,
  input  wire             pop,
  output logic [WIDTH-1:0] front,
  output logic            empty,
  output logic            full,
  output logic [7:0]      count
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [7:0]       occ;

  // Pointers wrap at DEPTH even when it is not a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    if (p == AW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   occ <= occ + 8'd1;
        2'b01:   occ <= occ - 8'd1;
        default: ;
      endcase
    end
  end

  assign front = mem[rd_ptr];
  assign empty = (occ == 8'd0);
  assign full  = (occ == 8'(DEPTH));
  assign count = occ;

endmodule

`default_nettype wire

/* hw/alu_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_subsystem #(
  parameter int CMD_DEPTH = 4,
  parameter int RES_DEPTH = 4
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire alu_pkg::wb_req_t wb_i,
  output alu_pkg::wb_rsp_t      wb_o
);
  import alu_pkg::*;

  logic        cmd_push;
  logic        cmd_pop;
  logic        cmd_empty;
  logic        cmd_full;
  logic [7:0]  cmd_count;
  alu_cmd_t    cmd_data;
  alu_cmd_t    cmd_front;
  logic        res_push;
  logic        res_pop;
  logic        res_empty;
  logic        res_full;
  logic [7:0]  res_count;
  alu_result_t res_data;
  alu_result_t res_front;

  alu_wb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_i      (wb_i),
    .wb_o      (wb_o),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_data),
    .cmd_full  (cmd_full),
    .cmd_count (cmd_count),
    .res_pop   (res_pop),
    .res_front (res_front),
    .res_empty (res_empty),
    .res_count (res_count)
  );

  // Command queue between the bus block and the execution unit
  alu_fifo #(.WIDTH($bits(alu_cmd_t)), .DEPTH(CMD_DEPTH)) cmd_fifo (
    .clk (clk), .rst_n (rst_n),
    .push (cmd_push), .push_data (cmd_data), .pop (cmd_pop),
    .front (cmd_front), .empty (cmd_empty), .full (cmd_full), .count (cmd_count)
  );

  alu_exec u_exec (
    .clk (clk), .rst_n (rst_n),
    .cmd_front (cmd_front), .cmd_empty (cmd_empty), .cmd_pop (cmd_pop),
    .res_push (res_push), .res_data (res_data), .res_full (res_full)
  );

  // Result queue back to the bus block
  alu_fifo #(.WIDTH($bits(alu_result_t)), .DEPTH(RES_DEPTH)) res_fifo (
    .clk (clk), .rst_n (rst_n),
    .push (res_push), .push_data (res_data), .pop (res_pop),
    .front (res_front), .empty (res_empty), .full (res_full), .count (res_count)
  );

endmodule

`default_nettype wire

/* hw/alu_wb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_wb_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire alu_pkg::wb_req_t   wb_i,
  output alu_pkg::wb_rsp_t        wb_o,
  output logic                    cmd_push,
  output alu_pkg::alu_cmd_t       cmd_data,
  input  wire                     cmd_full,
  input  wire [7:0]               cmd_count,
  output logic                    res_pop,
  input  wire alu_pkg::alu_result_t res_front,
  input  wire                     res_empty,
  input  wire [7:0]               res_count
);
  import alu_pkg::*;

  logic        ack_q;
  logic [31:0] rdata_q;
  logic [31:0] opa_q;
  logic [31:0] opb_q;
  logic [2:0]  flags_q;
  logic        req;
  logic        ready;
  logic        is_cmd;
  logic        is_res;
  logic        wr_acc;
  logic [31:0] rd_mux;

  // A new request is taken only outside the ack cycle
  assign req    = wb_i.cyc & wb_i.stb & ~ack_q;
  assign is_cmd = (wb_i.adr == REG_CMD);
  assign is_res = (wb_i.adr == REG_RESULT);

  // Wait states on a full command queue or an empty result queue
  always_comb begin
    ready = 1'b1;
    if (wb_i.we && is_cmd) begin
      ready = ~cmd_full;
    end
    if (!wb_i.we && is_res) begin
      ready = ~res_empty;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (wb_i.adr)
      REG_OPA: rd_mux = opa_q;
      REG_OPB: rd_mux = opb_q;
      REG_STATUS: begin
        rd_mux[STAT_CMD_COUNT_LSB +: 8] = cmd_count;
        rd_mux[STAT_RES_COUNT_LSB +: 8] = res_count;
        rd_mux[STAT_CMD_FULL]           = cmd_full;
        rd_mux[STAT_RES_EMPTY]          = res_empty;
      end
      REG_RESULT: rd_mux = res_front.value;
      REG_FLAGS:  rd_mux[2:0] = flags_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ready;
    end
  end

  // Read data is presented together with ack
  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= rd_mux;
    end
  end

  // Writes and queue side effects take effect in the ack cycle
  assign wr_acc   = ack_q & wb_i.we;
  assign cmd_push = wr_acc & is_cmd;
  assign res_pop  = ack_q & ~wb_i.we & is_res;
  assign cmd_data = '{op: alu_op_t'(wb_i.dat[3:0]), a: opa_q, b: opb_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opa_q   <= '0;
      opb_q   <= '0;
      flags_q <= '0;
    end else begin
      if (wr_acc && wb_i.adr == REG_OPA) begin
        opa_q <= wb_i.dat;
      end
      if (wr_acc && wb_i.adr == REG_OPB) begin
        opb_q <= wb_i.dat;
      end
      if (res_pop) begin
        flags_q[FLAG_OVERFLOW] <= res_front.overflow;
        flags_q[FLAG_EQUAL]    <= res_front.equal;
        flags_q[FLAG_ZERO]     <= res_front.zero;
      end
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

endmodule

`default_nettype wire

/* sources.f */
common/alu_pkg.sv
hw/alu_fifo.sv
alu/alu_shifter.sv
alu/alu_core.sv
alu/alu_exec.sv
hw/alu_wb_regs.sv
hw/alu_subsystem.sv
tb/alu_checker.sv
tb/tb_alu_subsystem.sv

/* tb/alu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_checker (
  input wire                   clk,
  input wire alu_pkg::wb_req_t wb_i,
  input wire alu_pkg::wb_rsp_t wb_o
);
  import alu_pkg::*;

  int          errors = 0;
  int          checks = 0;
  logic [7:0]  exp_adr [$];
  logic [31:0] exp_val [$];
  logic [31:0] exp_mask [$];

  function automatic string reg_name(input logic [7:0] adr);
    case (adr)
      REG_OPA:    return "OPA";
      REG_OPB:    return "OPB";
      REG_CMD:    return "CMD";
      REG_STATUS: return "STATUS";
      REG_RESULT: return "RESULT";
      REG_FLAGS:  return "FLAGS";
      default:    return "unknown register";
    endcase
  endfunction

  // A zero mask marks a polling read whose data is not compared
  task automatic expect_read(input logic [7:0] adr, input logic [31:0] value,
                             input logic [31:0] mask);
    exp_adr.push_back(adr);
    exp_val.push_back(value);
    exp_mask.push_back(mask);
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  task automatic final_check();
    if (exp_adr.size() != 0) begin
      report_failure($sformatf("%0d expected reads never completed", exp_adr.size()));
    end
  endtask

  // Bus inputs change 1 ns after the edge, so values seen here are settled
  always @(posedge clk) begin
    logic [7:0]  adr;
    logic [31:0] value;
    logic [31:0] mask;
    if (wb_o.ack && !wb_i.we) begin
      if (exp_adr.size() == 0) begin
        report_failure($sformatf("read of %s with nothing expected", reg_name(wb_i.adr)));
      end else begin
        adr   = exp_adr.pop_front();
        value = exp_val.pop_front();
        mask  = exp_mask.pop_front();
        if (adr != wb_i.adr) begin
          report_failure($sformatf("read of %s while %s was expected",
                                   reg_name(wb_i.adr), reg_name(adr)));
        end else if (((wb_o.dat ^ value) & mask) != 32'd0) begin
          $display("MISMATCH %s: expected 0x%08h, actual 0x%08h",
                   reg_name(adr), value, wb_o.dat);
          errors++;
        end
        if (mask != 32'd0) begin
          checks++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_alu_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_alu_subsystem;
  import alu_pkg::*;

  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [2:0]  flags;
  } row_t;

  localparam logic [31:0] ALL          = 32'hFFFF_FFFF;
  localparam logic [31:0] EMPTY_STATUS = 32'h0002_0000;

  logic    clk;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  row_t    rows [$];
  int      limit = 0;

  alu_subsystem #(.CMD_DEPTH(4), .RES_DEPTH(4)) dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_i  (wb_req),
    .wb_o  (wb_rsp)
  );

  alu_checker chk0 (
    .clk  (clk),
    .wb_i (wb_req),
    .wb_o (wb_rsp)
  );

  always #50 clk = ~clk;

  task automatic add_row(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] value, input logic [2:0] flags);
    row_t r;
    r = '{op: op, a: a, b: b, value: value, flags: flags};
    rows.push_back(r);
  endtask

  // Request stays up through the ack cycle, since push and pop happen there
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input logic [7:0] adr, input logic [31:0] value,
                          input logic [31:0] mask, output logic [31:0] rdata);
    chk0.expect_read(adr, value, mask);
    bus_cycle(1'b0, adr, 32'd0, rdata);
  endtask

  task automatic issue(input row_t r);
    write_reg(REG_OPA, r.a);
    write_reg(REG_OPB, r.b);
    write_reg(REG_CMD, {28'd0, r.op});
  endtask

  task automatic collect(input row_t r);
    logic [31:0] d;
    read_reg(REG_RESULT, r.value, ALL, d);
    read_reg(REG_FLAGS, {29'd0, r.flags}, ALL, d);
  endtask

  // Poll STATUS until the queues settle, then check it once
  task automatic wait_status(input logic [31:0] value);
    logic [31:0] d;
    int          tries;
    tries = 0;
    do begin
      read_reg(REG_STATUS, value, 32'd0, d);
      tries++;
    end while (d != value && tries < 50);
    read_reg(REG_STATUS, value, ALL, d);
  endtask

  initial begin
    logic [31:0] d;
    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_req = '0;
    // Logic and shift rows with shift amounts taken from B[4:0]
    add_row(ALU_AND,  32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 3'd0);
    add_row(ALU_OR,   32'hF0F0_1234, 32'h0FF0_FF00, 32'hFFF0_FF34, 3'd0);
    add_row(ALU_XOR,  32'hAAAA_5555, 32'hAAAA_5555, 32'h0000_0000, 3'd3);
    add_row(ALU_XOR,  32'h1234_5678, 32'hFFFF_0000, 32'hEDCB_5678, 3'd0);
    add_row(ALU_SLL,  32'h8000_0001, 32'h0000_0001, 32'h0000_0002, 3'd0);
    add_row(ALU_SLL,  32'h0000_0001, 32'h0000_001F, 32'h8000_0000, 3'd0);
    add_row(ALU_SLL,  32'h0000_0003, 32'h0000_0021, 32'h0000_0006, 3'd0);
    add_row(ALU_SRL,  32'h8000_0000, 32'h0000_001F, 32'h0000_0001, 3'd0);
    add_row(ALU_SRL,  32'h1234_5678, 32'h0000_0024, 32'h0123_4567, 3'd0);
    add_row(ALU_SRA,  32'h8000_0000, 32'h0000_001F, 32'hFFFF_FFFF, 3'd0);
    add_row(ALU_SRA,  32'hF000_0010, 32'h0000_0004, 32'hFF00_0001, 3'd0);
    add_row(ALU_SRA,  32'h7000_0000, 32'h0000_003F, 32'h0000_0000, 3'd1);
    add_row(ALU_SRA,  32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 3'd0);
    add_row(ALU_SLL,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 3'd0);
    add_row(ALU_SRL,  32'h8000_0001, 32'h0000_0001, 32'h4000_0000, 3'd0);
    add_row(ALU_SRA,  32'h8000_0002, 32'h0000_0021, 32'hC000_0001, 3'd0);
    add_row(4'h4,     32'h0000_1234, 32'h0000_5678, 32'h0000_0000, 3'd1);
    // Arithmetic rows with flags as {overflow, equal, zero}
    add_row(ALU_ADD,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 3'd1);
    add_row(ALU_ADD,  32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 3'd4);
    add_row(ALU_ADD,  32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 3'd7);
    add_row(ALU_ADD,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C, 3'd0);
    add_row(ALU_ADD,  32'h0000_1000, 32'h0000_1000, 32'h0000_2000, 3'd2);
    add_row(ALU_SUB,  32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 3'd4);
    add_row(ALU_SUB,  32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 3'd4);
    add_row(ALU_SUB,  32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 3'd3);
    add_row(ALU_SUB,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 3'd0);
    // Compares
    add_row(ALU_SLT,  32'h8000_0000, 32'h0000_0001, 32'h0000_0001, 3'd0);
    add_row(ALU_SLT,  32'h0000_0001, 32'h8000_0000, 32'h0000_0000, 3'd1);
    add_row(ALU_SLTU, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000, 3'd1);
    add_row(ALU_SLTU, 32'h0000_0001, 32'h8000_0000, 32'h0000_0001, 3'd0);
    add_row(ALU_SLT,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 3'd3);
    add_row(ALU_SLTU, 32'h0000_0007, 32'h0000_0007, 32'h0000_0000, 3'd3);
    limit = rows.size() * 200 + 2000;

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    read_reg(REG_STATUS, EMPTY_STATUS, ALL, d);
    read_reg(REG_OPA, 32'd0, ALL, d);
    read_reg(REG_OPB, 32'd0, ALL, d);
    read_reg(REG_FLAGS, 32'd0, ALL, d);

    foreach (rows[i]) begin
      issue(rows[i]);
      collect(rows[i]);
    end

    // Nine commands fill both queues and the exec output register
    for (int i = 0; i < 9; i++) begin
      issue(rows[i]);
    end
    wait_status(32'h0001_0404);
    for (int i = 0; i < 9; i++) begin
      collect(rows[i]);
    end
    read_reg(REG_STATUS, EMPTY_STATUS, ALL, d);

    // Result count falls by one per RESULT read
    for (int i = 0; i < 3; i++) begin
      issue(rows[i]);
    end
    wait_status(32'h0000_0300);
    for (int i = 0; i < 3; i++) begin
      read_reg(REG_RESULT, rows[i].value, ALL, d);
      read_reg(REG_STATUS, (i == 2) ? EMPTY_STATUS : (32'(2 - i) << 8), ALL, d);
    end

    chk0.final_check();
    $display("checks %0d, errors %0d", chk0.checks, chk0.errors);
    if (chk0.errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("ERROR: bus stalled, no acknowledge within %0d cycles", limit);
    $display("checks %0d, errors %0d", chk0.checks, chk0.errors + 1);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
